// File: Bender.yml
package:
  name: tengbaser_infrastructure

sources:
  - files:
      - design/tengbaser_pkg.sv
      - design/tengbaser_reset_seq.sv
      - design/tengbaser_mgmt_regs.sv
      - design/tengbaser_infrastructure.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_tengbaser.sv

// File: all.f
+incdir+bench
design/tengbaser_pkg.sv
design/tengbaser_reset_seq.sv
design/tengbaser_mgmt_regs.sv
design/tengbaser_infrastructure.sv
bench/tb_tengbaser.sv

// File: bench/tb_tengbaser_tests.svh
// bring-up order with lock 5 cycles after qpllreset falls
task automatic test_bring_up();
  int cycles;
  int errs;
  errs       = n_errors;
  lock_delay = 5;
  apply_reset();
  wait_level(p_qpllreset, 1'b0, 64, "qpllreset", cycles);
  if (cycles != qpll_rst_cycles)
    flag_error($sformatf("qpllreset held %0d cycles", cycles));
  wait_level(p_gttxreset, 1'b1, 64, "gttxreset", cycles);
  // gt resets only once the pll reports lock
  if (qplllock !== 1'b1)
    flag_error("gttxreset rose without qplllock");
  // rx reset rises together with tx reset
  if (gtrxreset !== 1'b1)
    flag_error("gtrxreset not high with gttxreset");
  wait_level(p_gttxreset, 1'b0, 64, "gttxreset", cycles);
  if (cycles != gt_rst_cycles)
    flag_error($sformatf("gt resets held %0d cycles", cycles));
  if (txuserrdy !== 1'b1 || gtrxreset !== 1'b0 || areset_clk156 !== 1'b1)
    flag_error("txuserrdy, gtrxreset or areset wrong as gt resets fall");
  wait_level(p_done, 1'b1, 128, "reset_counter_done", cycles);
  if (cycles != user_rdy_cycles)
    flag_error($sformatf("done came %0d cycles after txuserrdy", cycles));
  if (areset_clk156 !== 1'b0)
    flag_error("areset_clk156 still high with done");
  finish_test("bring_up", errs);
endtask

// lock withheld so the timeout sends the sequencer back to qpll reset
task automatic test_lock_timeout();
  int cycles;
  int errs;
  errs       = n_errors;
  lock_delay = -1;
  apply_reset();
  wait_level(p_qpllreset, 1'b0, 64, "qpllreset", cycles);
  wait_level(p_qpllreset, 1'b1, lock_timeout_cycles + 8, "qpllreset", cycles);
  if (cycles != lock_timeout_cycles)
    flag_error($sformatf("lock timeout after %0d cycles", cycles));
  lock_delay = 5;
  wait_level(p_done, 1'b1, 400, "reset_counter_done", cycles);
  finish_test("lock_timeout", errs);
endtask

// two lock losses after done with the flag cleared on read and the count following
task automatic test_lock_loss();
  int       cycles;
  int       errs;
  wb_data_t rdata;
  errs = n_errors;
  for (int k = 1; k <= 2; k++) begin
    lock_delay = -1;
    step();
    step();
    if (txuserrdy !== 1'b0 || reset_counter_done !== 1'b0)
      flag_error("txuserrdy or done still high one edge after lock loss");
    wb_read(addr_status, rdata);
    if (rdata !== 32'h4)
      flag_error($sformatf("status read %h, expected 4", rdata));
    wb_read(addr_status, rdata);
    if (rdata !== 32'h0)
      flag_error($sformatf("second status read %h, expected 0", rdata));
    wb_read(addr_lol_cnt, rdata);
    if (rdata !== k)
      flag_error($sformatf("lol_cnt read %0d, expected %0d", rdata, k));
    lock_delay = 5;
    wait_level(p_done, 1'b1, 1000, "reset_counter_done", cycles);
  end
  finish_test("lock_loss", errs);
endtask

// soft restart from done and then both loopback bits
task automatic test_soft_restart();
  int       cycles;
  int       errs;
  wb_data_t rdata;
  errs = n_errors;
  wb_write(addr_ctrl, 32'h1);
  if (qpllreset !== 1'b1 || txuserrdy !== 1'b0)
    flag_error("soft restart did not return to qpll reset");
  wb_read(addr_ctrl, rdata);
  if (rdata !== 32'h0)
    flag_error($sformatf("ctrl read %h after restart, expected 0", rdata));
  wb_write(addr_ctrl, 32'h6);
  if (pcs_loopback !== 1'b1 || pma_loopback !== 1'b1)
    flag_error("loopback ports not set by ctrl write");
  wb_read(addr_ctrl, rdata);
  if (rdata !== 32'h6)
    flag_error($sformatf("ctrl read %h, expected 6", rdata));
  wait_level(p_done, 1'b1, 1000, "reset_counter_done", cycles);
  finish_test("soft_restart", errs);
endtask

// full register map readback and then the forwarded rx clock
task automatic test_bus_and_clock();
  int       errs;
  wb_data_t rdata;
  wb_data_t expect_map[4];
  errs          = n_errors;
  // ctrl 6, lock and done up, two losses counted, address 3 empty
  expect_map[0] = 32'h6;
  expect_map[1] = 32'h3;
  expect_map[2] = 32'h2;
  expect_map[3] = 32'h0;
  wb_write(2'd3, 32'hffff_ffff);
  for (int a = 0; a < 4; a++) begin
    wb_read(wb_adr_t'(a), rdata);
    if (rdata !== expect_map[a])
      flag_error($sformatf("address %0d read %h, expected %h", a, rdata, expect_map[a]));
  end
  for (int n = 0; n < 4; n++) begin
    @(posedge clk156);
    #1;
    if (xgmii_rx_clk !== 1'b0)
      flag_error("xgmii_rx_clk not low after rising edge");
    @(negedge clk156);
    #1;
    if (xgmii_rx_clk !== 1'b1)
      flag_error("xgmii_rx_clk not high after falling edge");
  end
  finish_test("bus_and_clock", errs);
endtask

// File: bench/tb_tengbaser.sv
`timescale 1ns/10ps

module tb_tengbaser import tengbaser_pkg::*; ();

  // dut outputs that the wait helper can follow
  typedef enum int {
    p_qpllreset,
    p_gttxreset,
    p_done
  } probe_t;

  logic     clk156;
  logic     rst_n;
  logic     qplllock;
  logic     cyc;
  logic     stb;
  logic     we;
  wb_adr_t  adr;
  wb_data_t dat_w;
  wb_data_t dat_r;
  logic     ack;
  logic     qpllreset;
  logic     gttxreset;
  logic     gtrxreset;
  logic     txuserrdy;
  logic     reset_counter_done;
  logic     areset_clk156;
  logic     pcs_loopback;
  logic     pma_loopback;
  logic     xgmii_rx_clk;

  // cycles from qpllreset fall to lock, negative holds lock low
  int lock_delay;
  int lock_wait;
  int n_errors;
  int n_tests;

  tengbaser_infrastructure dut (.*);

  // 156.25 MHz stand-in, 10 ns period
  initial begin
    clk156 = 1'b0;
    forever #5 clk156 = ~clk156;
  end

  // qpll model, lock follows qpllreset with a programmable delay
  task automatic update_qpll_lock();
    if (qpllreset || lock_delay < 0) begin
      lock_wait = 0;
      qplllock  = 1'b0;
    end else begin
      lock_wait++;
      if (lock_wait >= lock_delay)
        qplllock = 1'b1;
    end
  endtask

  // one clock, inputs and samples 1 ns after the rising edge
  task automatic step();
    @(posedge clk156);
    #1;
    update_qpll_lock();
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) step();
    rst_n = 1'b1;
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    n_errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    n_tests++;
    $display("test %s finished, %0d errors", name, n_errors - errs_before);
  endtask

  function automatic logic probe(input probe_t sel);
    case (sel)
      p_qpllreset: return qpllreset;
      p_gttxreset: return gttxreset;
      default:     return reset_counter_done;
    endcase
  endfunction

  // counts clocks until the probed output reaches level
  task automatic wait_level(input probe_t sel, input logic level, input int limit,
                            input string what, output int cycles);
    cycles = 0;
    while (probe(sel) !== level && cycles < limit) begin
      step();
      cycles++;
    end
    if (probe(sel) !== level) begin
      $display("timeout: %s did not go to %0b within %0d cycles", what, level, limit);
      n_errors++;
    end
  endtask

  // classic cycle, request held until ack, ack expected one clock later
  task automatic bus_cycle(input logic write, input wb_adr_t a, input wb_data_t wdata,
                           output wb_data_t rdata);
    int waited;
    waited = 0;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = write;
    adr    = a;
    dat_w  = wdata;
    while (ack !== 1'b1 && waited < 8) begin
      step();
      waited++;
    end
    rdata = dat_r;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    if (ack !== 1'b1) begin
      $display("timeout: register slave gave no ack within 8 cycles");
      n_errors++;
    end else if (waited != 1) begin
      flag_error($sformatf("ack %0d cycles after stb, expected 1", waited));
    end
    // idle clock so ack is low again before the next request
    step();
  endtask

  task automatic wb_write(input wb_adr_t a, input wb_data_t d);
    wb_data_t unused;
    bus_cycle(1'b1, a, d, unused);
  endtask

  task automatic wb_read(input wb_adr_t a, output wb_data_t d);
    bus_cycle(1'b0, a, '0, d);
  endtask

  `include "tb_tengbaser_tests.svh"

  initial begin
    rst_n      = 1'b0;
    qplllock   = 1'b0;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    dat_w      = '0;
    lock_delay = 5;
    lock_wait  = 0;
    n_errors   = 0;
    n_tests    = 0;
    test_bring_up();
    test_lock_timeout();
    test_lock_loss();
    test_soft_restart();
    test_bus_and_clock();
    $display("tests run %0d, errors %0d", n_tests, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: design/tengbaser_infrastructure.sv
`timescale 1ns/10ps

module tengbaser_infrastructure import tengbaser_pkg::*; (
  input  logic     clk156,
  input  logic     rst_n,
  input  logic     qplllock,
  // host bus, wishbone classic
  input  logic     cyc,
  input  logic     stb,
  input  logic     we,
  input  wb_adr_t  adr,
  input  wb_data_t dat_w,
  output wb_data_t dat_r,
  output logic     ack,
  // transceiver reset controls
  output logic     qpllreset,
  output logic     gttxreset,
  output logic     gtrxreset,
  output logic     txuserrdy,
  output logic     reset_counter_done,
  output logic     areset_clk156,
  // loopback enables from ctrl
  output logic     pcs_loopback,
  output logic     pma_loopback,
  output logic     xgmii_rx_clk
);

  // soft restart pulse, regs to sequencer
  logic restart;

  tengbaser_reset_seq reset_seq_i (
    .clk156             (clk156),
    .rst_n              (rst_n),
    .qplllock           (qplllock),
    .restart            (restart),
    .qpllreset          (qpllreset),
    .gttxreset          (gttxreset),
    .gtrxreset          (gtrxreset),
    .txuserrdy          (txuserrdy),
    .reset_counter_done (reset_counter_done),
    .areset_clk156      (areset_clk156)
  );

  tengbaser_mgmt_regs mgmt_regs_i (
    .clk156             (clk156),
    .rst_n              (rst_n),
    .cyc                (cyc),
    .stb                (stb),
    .we                 (we),
    .adr                (adr),
    .dat_w              (dat_w),
    .dat_r              (dat_r),
    .ack                (ack),
    .qplllock           (qplllock),
    .reset_counter_done (reset_counter_done),
    .restart            (restart),
    .pcs_loopback       (pcs_loopback),
    .pma_loopback       (pma_loopback)
  );

  // forwarded rx clock, 0 on the rising edge and 1 on the falling edge
  // same waveform an output ddr cell with d1=0, d2=1 would give
  assign xgmii_rx_clk = ~clk156;

endmodule

// File: design/tengbaser_mgmt_regs.sv
`timescale 1ns/10ps

module tengbaser_mgmt_regs import tengbaser_pkg::*; (
  input  logic     clk156,
  input  logic     rst_n,
  input  logic     cyc,
  input  logic     stb,
  input  logic     we,
  input  wb_adr_t  adr,
  input  wb_data_t dat_w,
  output wb_data_t dat_r,
  output logic     ack,
  input  logic     qplllock,
  input  logic     reset_counter_done,
  output logic     restart,
  output logic     pcs_loopback,
  output logic     pma_loopback
);

  // access accepted this cycle and ack goes up on the edge
  logic     acc;
  logic     wr_en;
  logic     rd_en;
  logic     qplllock_q;
  // lock fell while the link was up
  logic     lock_fall;
  logic     lock_lost_ll;
  lol_cnt_t lol_cnt;
  wb_data_t rd_data;

  // ack low in the accept cycle keeps ack to one cycle
  assign acc   = cyc && stb && !ack;
  assign wr_en = acc && we;
  assign rd_en = acc && !we;

  // done still high here since the sequencer drops it on the same edge
  assign lock_fall = qplllock_q && !qplllock && reset_counter_done;

  // bus handshake
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= acc;
    end
  end

  // ctrl register
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      restart      <= 1'b0;
      pcs_loopback <= 1'b0;
      pma_loopback <= 1'b0;
    end else begin
      // single cycle pulse that is never stored
      restart <= wr_en && (adr == addr_ctrl) && dat_w[ctrl_restart_bit];
      if (wr_en && (adr == addr_ctrl)) begin
        pcs_loopback <= dat_w[ctrl_pcs_lpbk_bit];
        pma_loopback <= dat_w[ctrl_pma_lpbk_bit];
      end
    end
  end

  // lock falling edge detect
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      qplllock_q <= 1'b0;
    end else begin
      qplllock_q <= qplllock;
    end
  end

  // sticky latched-low lock flag and loss counter
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      lock_lost_ll <= 1'b0;
      lol_cnt      <= '0;
    end else begin
      // new event beats the read clear
      if (lock_fall) begin
        lock_lost_ll <= 1'b1;
      end else if (rd_en && (adr == addr_status)) begin
        lock_lost_ll <= 1'b0;
      end
      // holds at all ones
      if (lock_fall && (lol_cnt != '1)) begin
        lol_cnt <= lol_cnt + 1'b1;
      end
    end
  end

  // read mux where unused bits and address 3 read zero
  always_comb begin
    rd_data = '0;
    case (adr)
      addr_ctrl: begin
        rd_data[ctrl_pcs_lpbk_bit] = pcs_loopback;
        rd_data[ctrl_pma_lpbk_bit] = pma_loopback;
      end
      addr_status: begin
        rd_data[stat_lock_bit]    = qplllock;
        rd_data[stat_done_bit]    = reset_counter_done;
        rd_data[stat_lock_ll_bit] = lock_lost_ll;
      end
      addr_lol_cnt: begin
        rd_data[lol_cnt_w-1:0] = lol_cnt;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // read data valid alongside ack and shows the flag before its clear
  always_ff @(posedge clk156) begin
    if (rd_en) begin
      dat_r <= rd_data;
    end
  end

endmodule

// File: design/tengbaser_pkg.sv
package tengbaser_pkg;

  // field widths
  localparam int unsigned wb_adr_w   = 2;
  localparam int unsigned wb_data_w  = 32;
  localparam int unsigned hold_cnt_w = 10;
  localparam int unsigned lol_cnt_w  = 8;

  // word address on the host bus
  typedef logic [wb_adr_w-1:0]   wb_adr_t;
  // host bus data
  typedef logic [wb_data_w-1:0]  wb_data_t;
  // hold timer, doubles as the lock timeout
  typedef logic [hold_cnt_w-1:0] hold_cnt_t;
  // lock-loss event count, saturating
  typedef logic [lol_cnt_w-1:0]  lol_cnt_t;

  // bring-up order, one state per phase
  typedef enum logic [2:0] {
    qpll_rst,
    wait_lock,
    gt_rst,
    user_rdy,
    done
  } seq_state_t;

  // register map, word addresses
  localparam wb_adr_t addr_ctrl    = 2'd0;
  localparam wb_adr_t addr_status  = 2'd1;
  localparam wb_adr_t addr_lol_cnt = 2'd2;

  // ctrl bit positions
  localparam int unsigned ctrl_restart_bit  = 0;
  localparam int unsigned ctrl_pcs_lpbk_bit = 1;
  localparam int unsigned ctrl_pma_lpbk_bit = 2;

  // status bit positions
  localparam int unsigned stat_lock_bit     = 0;
  localparam int unsigned stat_done_bit     = 1;
  localparam int unsigned stat_lock_ll_bit  = 2;

  // sequencer phase lengths in clk156 cycles
  localparam int unsigned qpll_rst_cycles     = 16;
  localparam int unsigned lock_timeout_cycles = 256;
  localparam int unsigned gt_rst_cycles       = 32;
  localparam int unsigned user_rdy_cycles     = 64;

endpackage

// File: design/tengbaser_reset_seq.sv
`timescale 1ns/10ps

module tengbaser_reset_seq import tengbaser_pkg::*; (
  input  logic clk156,
  input  logic rst_n,
  input  logic qplllock,
  input  logic restart,
  output logic qpllreset,
  output logic gttxreset,
  output logic gtrxreset,
  output logic txuserrdy,
  output logic reset_counter_done,
  output logic areset_clk156
);

  seq_state_t state;
  seq_state_t state_nxt;
  hold_cnt_t  cnt;
  // restart the hold count on the coming edge
  logic       cnt_clr;
  // current phase has run its full length
  logic       hold_end;
  // lock gone after the pll was seen locked
  logic       lock_drop;

  // wait_lock handles a missing lock itself through the timeout
  assign lock_drop = !qplllock &&
                     (state == gt_rst || state == user_rdy || state == done);

  // end of phase, compared against the last count of each phase
  always_comb begin
    case (state)
      qpll_rst:
        hold_end = (cnt == hold_cnt_t'(qpll_rst_cycles - 1));
      wait_lock:
        hold_end = (cnt == hold_cnt_t'(lock_timeout_cycles - 1));
      gt_rst:
        hold_end = (cnt == hold_cnt_t'(gt_rst_cycles - 1));
      user_rdy:
        hold_end = (cnt == hold_cnt_t'(user_rdy_cycles - 1));
      default:
        hold_end = 1'b0;
    endcase
  end

  // next state
  always_comb begin
    state_nxt = state;
    cnt_clr   = 1'b0;
    if (restart || lock_drop) begin
      // back to the start, whole order is retried
      state_nxt = qpll_rst;
      cnt_clr   = 1'b1;
    end else begin
      case (state)
        qpll_rst: begin
          if (hold_end) begin
            state_nxt = wait_lock;
          end
        end
        wait_lock: begin
          // first locked cycle wins over the timeout
          if (qplllock) begin
            state_nxt = gt_rst;
          end else if (hold_end) begin
            state_nxt = qpll_rst;
          end
        end
        gt_rst: begin
          if (hold_end) begin
            state_nxt = user_rdy;
          end
        end
        user_rdy: begin
          if (hold_end) begin
            state_nxt = done;
          end
        end
        default: begin
          state_nxt = done;
        end
      endcase
      // every phase starts counting from zero
      if (state_nxt != state) begin
        cnt_clr = 1'b1;
      end
    end
  end

  // state and hold counter
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      state <= qpll_rst;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (cnt_clr) begin
        cnt <= '0;
      end else if (state != done) begin
        cnt <= cnt + 1'b1;
      end
      // counter idles once up
    end
  end

  // outputs follow the state being entered, so they change on the same edge
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      qpllreset          <= 1'b1;
      gttxreset          <= 1'b0;
      gtrxreset          <= 1'b0;
      txuserrdy          <= 1'b0;
      reset_counter_done <= 1'b0;
      areset_clk156      <= 1'b1;
    end else begin
      qpllreset          <= (state_nxt == qpll_rst);
      // tx and rx gt resets held together
      gttxreset          <= (state_nxt == gt_rst);
      gtrxreset          <= (state_nxt == gt_rst);
      // user ready stays up through done
      txuserrdy          <= (state_nxt == user_rdy) || (state_nxt == done);
      reset_counter_done <= (state_nxt == done);
      // core reset released together with done
      areset_clk156      <= (state_nxt != done);
    end
  end

endmodule
